// File: vlog.f
+incdir+hw
hw/icache_pkg.sv
hw/icache_way.sv
hw/icache_hit_select.sv
hw/icache_ctrl.sv
hw/icache_top.sv
bench/icache_tb.sv

// File: Makefile
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
TOP ?= icache_tb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= STATUS: PASS

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(SIM): $(FILELIST) $(wildcard hw/*.sv hw/*.svh bench/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/icache_tb.sv
/*
 * instruction cache testbench
 * clock, reset, burst memory model with LFSR ready delay
 * fetch driver, concurrent checks and the closing report
 */
`include "icache_defines.svh"

module icache_tb;

	localparam int TIMEOUT = 200;	// cycles per wait

	typedef enum logic [2:0] {M_IDLE, M_WAIT, M_ACK, M_BEAT, M_DONE} mem_state_t;

	logic clock = 1'b0;
	logic reset;
	logic req_valid;
	logic req_ready;
	logic [31:0] req_addr;
	logic resp_valid;
	logic resp_ready;
	logic [31:0] resp_data;
	logic mem_req_valid;
	logic mem_req_ready = 1'b0;
	logic [31:0] mem_req_addr;
	logic mem_resp_valid = 1'b0;
	logic mem_resp_last = 1'b0;
	logic [31:0] mem_resp_data = '0;
	logic fence;

	mem_state_t mem_state = M_IDLE;
	logic [1:0] mem_delay = '0;
	logic [31:0] mem_addr = '0;
	logic [31:0] mem_lfsr = 32'h18ec_5144;
	logic [31:0] stim_lfsr = 32'h18ec_5144;
	int beat = 0;
	int req_count = 0;	// bursts accepted by the memory

	logic [31:0] exp_addr = '0;
	string test_name = "reset";
	int base_requests = 0;
	int base_errors = 0;
	int errors = 0;
	int assert_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	icache_top icache_top_i (.*);

	always #5 clock = ~clock;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// taps 32 22 2 1
	endfunction

	// memory holds the word address xor a fixed pattern
	function automatic logic [31:0] model_word(input logic [31:0] addr);
		return (addr >> 2) ^ 32'h5a5a_0000;
	endfunction

	always @(posedge clock) begin : mem_model
		logic [31:0] stepped;
		stepped = lfsr_next(lfsr_next(mem_lfsr));	// two bits for the delay
		if (reset) begin
			mem_state <= M_IDLE;
			mem_req_ready <= 1'b0;
			mem_resp_valid <= 1'b0;
			mem_resp_last <= 1'b0;
		end else begin
			case (mem_state)
				M_IDLE: begin
					if (mem_req_valid) begin
						mem_lfsr <= stepped;
						mem_delay <= stepped[1:0];
						mem_state <= M_WAIT;
					end
				end
				M_WAIT: begin
					if (mem_delay == 2'd0) begin
						mem_req_ready <= 1'b1;
						mem_state <= M_ACK;
					end else begin
						mem_delay <= mem_delay - 2'd1;
					end
				end
				M_ACK: begin	// request taken at this edge
					mem_req_ready <= 1'b0;
					mem_addr <= mem_req_addr;
					req_count <= req_count + 1;
					beat <= 0;
					mem_state <= M_BEAT;
				end
				M_BEAT: begin
					mem_resp_valid <= 1'b1;
					mem_resp_data <= model_word(mem_addr + 32'(beat * 4));
					mem_resp_last <= (beat == `ICACHE_BEATS - 1);
					beat <= beat + 1;
					if (beat == `ICACHE_BEATS - 1) begin
						mem_state <= M_DONE;
					end
				end
				default: begin
					mem_resp_valid <= 1'b0;
					mem_resp_last <= 1'b0;
					mem_state <= M_IDLE;
				end
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		resp_valid && resp_ready |-> resp_data == model_word(exp_addr))
	else begin
		$display("MISMATCH %s expected %h actual %h", test_name,
			model_word($sampled(exp_addr)), $sampled(resp_data));
		assert_errors++;
	end

	// back-pressure holds the word
	assert property (@(posedge clock) disable iff (reset)
		resp_valid && !resp_ready |=> $stable(resp_data))
	else begin
		$display("%s: response data changed while the response was stalled", test_name);
		assert_errors++;
	end

	assert property (@(posedge clock) disable iff (reset) resp_valid |-> !req_ready)
	else begin
		$display("%s: request side ready while a response is pending", test_name);
		assert_errors++;
	end

	assert property (@(posedge clock) disable iff (reset)
		mem_req_valid |-> mem_req_addr[`ICACHE_OFF_W-1:0] == '0)
	else begin
		$display("%s: memory request address %h is not line aligned", test_name,
			$sampled(mem_req_addr));
		assert_errors++;
	end

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_next(stim_lfsr);
			v = {v[30:0], stim_lfsr[0]};
		end
	endtask

	// one fetch started right after a rising edge
	task automatic fetch(input logic [31:0] addr, input int stall);
		int t;
		exp_addr <= addr;
		req_addr <= addr;
		req_valid <= 1'b1;
		resp_ready <= (stall == 0);
		t = 0;
		do begin
			@(posedge clock);
			t++;
		end while (!req_ready && t < TIMEOUT);
		req_valid <= 1'b0;
		if (!req_ready) begin
			$display("%s: request for %h was never accepted", test_name, addr);
			errors++;
			return;
		end
		t = 0;
		do begin
			@(posedge clock);
			t++;
		end while (!resp_valid && t < TIMEOUT);
		if (!resp_valid) begin
			$display("%s: no response for %h", test_name, addr);
			errors++;
		end else if (stall > 0) begin
			repeat (stall - 1) @(posedge clock);
			resp_ready <= 1'b1;
			@(posedge clock);	// handshake edge
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		base_requests = req_count;
		base_errors = errors + assert_errors;
	endtask

	task automatic check_requests(input int expected);
		assert (req_count - base_requests == expected)
		else begin
			$display("MISMATCH %s memory requests expected %0d actual %0d", test_name,
				expected, req_count - base_requests);
			errors++;
		end
		base_requests = req_count;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors + assert_errors == base_errors) begin
			$display("test %s passed", test_name);
		end else begin
			tests_failed++;
			$display("test %s failed", test_name);
		end
	endtask

	initial begin
		logic [31:0] v;
		reset <= 1'b1;
		req_valid <= 1'b0;
		req_addr <= '0;
		resp_ready <= 1'b0;
		fence <= 1'b0;
		repeat (8) @(posedge clock);
		reset <= 1'b0;

		start_test("cold_read");
		fetch(32'h0000_0100, 0);
		check_requests(1);
		finish_test();

		start_test("line_hit");
		for (int w = 0; w < 4; w++) begin
			fetch(32'h0000_0100 + 32'(w * 4), 0);
		end
		check_requests(0);
		finish_test();

		start_test("round_robin");	// A, B, C all map to set 1
		fetch(32'h0000_0214, 0);
		fetch(32'h0000_1218, 0);
		fetch(32'h0000_0210, 0);
		check_requests(2);
		fetch(32'h0000_221c, 0);	// replaces A
		check_requests(1);
		fetch(32'h0000_1210, 0);
		check_requests(0);
		fetch(32'h0000_0218, 0);
		check_requests(1);
		finish_test();

		start_test("fence");
		fetch(32'h0000_0108, 0);
		check_requests(0);
		fence <= 1'b1;
		@(posedge clock);
		fence <= 1'b0;
		fetch(32'h0000_0108, 0);
		check_requests(1);
		finish_test();

		start_test("back_pressure");
		for (int i = 0; i < 6; i++) begin
			take_bits(2, v);
			fetch(32'h0000_0300 + 32'(i * 4), 1 + int'(v));
		end
		finish_test();

		start_test("random_sweep");
		for (int i = 0; i < 200; i++) begin
			take_bits(10, v);
			fetch(v << 2, 0);	// word aligned and below 4 KiB
		end
		finish_test();

		$display("tests %0d, failed %0d, check errors %0d, assertion errors %0d",
			tests_run, tests_failed, errors, assert_errors);
		if (errors + assert_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: hw/icache_top.sv
/*
 * instruction cache top
 * control block, generated ways and hit select
 */
`include "icache_defines.svh"

module icache_top (
	input  logic clock,
	input  logic reset,
	input  logic req_valid,
	output logic req_ready,
	input  logic [`ICACHE_ADDR_W-1:0] req_addr,
	output logic resp_valid,
	input  logic resp_ready,
	output logic [`ICACHE_WORD_W-1:0] resp_data,
	output logic mem_req_valid,
	input  logic mem_req_ready,
	output logic [`ICACHE_ADDR_W-1:0] mem_req_addr,
	input  logic mem_resp_valid,
	input  logic mem_resp_last,
	input  logic [`ICACHE_WORD_W-1:0] mem_resp_data,
	input  logic fence
);
	import icache_pkg::*;

	tag_t line_tag;
	logic [`ICACHE_INDEX_W-1:0] line_index;
	logic [`ICACHE_WSEL_W-1:0] word_sel;
	logic [`ICACHE_WAYS-1:0] fill_sel;	// one-hot victim
	logic fill_shift;
	logic fill_last;
	logic [`ICACHE_WORD_W-1:0] fill_data;
	logic invalidate;
	logic [`ICACHE_WAYS-1:0] hit_vec;
	line_t line_vec [`ICACHE_WAYS];
	logic any_hit;
	logic [`ICACHE_WORD_W-1:0] hit_word;

	icache_ctrl ctrl_i (
		.clock, .reset,
		.req_valid, .req_ready, .req_addr,
		.resp_valid, .resp_ready, .resp_data,
		.mem_req_valid, .mem_req_ready, .mem_req_addr,
		.mem_resp_valid, .mem_resp_last, .mem_resp_data,
		.fence,
		.line_tag, .line_index, .word_sel,
		.fill_sel, .fill_shift, .fill_last, .fill_data,
		.invalidate, .any_hit, .hit_word
	);

	for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : g_way
		icache_way way_i (
			.clock, .reset,
			.line_tag, .line_index,
			.fill_sel(fill_sel[g]),
			.fill_shift, .fill_last, .fill_data,
			.invalidate,
			.hit(hit_vec[g]),
			.line_data(line_vec[g])
		);
	end

	icache_hit_select hit_select_i (
		.hit_vec, .line_vec, .word_sel,
		.any_hit,
		.word(hit_word)
	);

endmodule

// File: hw/icache_ctrl.sv
/*
 * cache control
 * request capture and the idle/lookup/refill/respond/fence FSM
 * round-robin victim per set, burst request and refill steering
 */
`include "icache_defines.svh"

module icache_ctrl (
	input  logic clock,
	input  logic reset,
	input  logic req_valid,
	output logic req_ready,
	input  icache_pkg::fetch_addr_t req_addr,
	output logic resp_valid,
	input  logic resp_ready,
	output logic [`ICACHE_WORD_W-1:0] resp_data,
	output logic mem_req_valid,
	input  logic mem_req_ready,
	output logic [`ICACHE_ADDR_W-1:0] mem_req_addr,
	input  logic mem_resp_valid,
	input  logic mem_resp_last,
	input  logic [`ICACHE_WORD_W-1:0] mem_resp_data,
	input  logic fence,
	output icache_pkg::tag_t line_tag,
	output logic [`ICACHE_INDEX_W-1:0] line_index,
	output logic [`ICACHE_WSEL_W-1:0] word_sel,
	output logic [`ICACHE_WAYS-1:0] fill_sel,
	output logic fill_shift,
	output logic fill_last,
	output logic [`ICACHE_WORD_W-1:0] fill_data,
	output logic invalidate,
	input  logic any_hit,
	input  logic [`ICACHE_WORD_W-1:0] hit_word
);
	import icache_pkg::*;

	localparam int WAY_W = (`ICACHE_WAYS > 1) ? $clog2(`ICACHE_WAYS) : 1;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_REFILL,
		ST_RESPOND,
		ST_FENCE
	} state_t;

	state_t state;
	fetch_addr_t addr_q;	// held for the whole fetch
	fetch_addr_t line_addr;
	logic [WAY_W-1:0] victim [`ICACHE_SETS];
	logic fence_pend;
	logic req_fire;
	logic fence_take;
	logic refill_done;

	assign req_ready = (state == ST_IDLE) && !fence_pend;
	assign req_fire = req_valid && req_ready;
	// a request in the same cycle wins over the fence
	assign fence_take = (state == ST_IDLE) && !req_fire && (fence || fence_pend);

	assign line_tag = addr_q.f.tag;
	assign line_index = addr_q.f.index;
	assign word_sel = addr_q.f.word;

	always_comb begin
		line_addr = addr_q;
		line_addr.f.word = '0;
		line_addr.f.byte_off = '0;
	end
	assign mem_req_addr = line_addr.raw;

	// beats go straight to the victim way
	assign fill_shift = (state == ST_REFILL) && mem_resp_valid;
	assign fill_last = mem_resp_last;
	assign fill_data = mem_resp_data;
	assign refill_done = fill_shift && fill_last;
	assign invalidate = (state == ST_FENCE);

	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			fill_sel[w] = (state == ST_REFILL) && (victim[line_index] == WAY_W'(w));
		end
	end

	always_ff @(posedge clock) begin
		if (req_fire) begin
			addr_q <= req_addr;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			fence_pend <= 1'b0;
		end else if (fence_take) begin
			fence_pend <= 1'b0;
		end else if (fence) begin
			fence_pend <= 1'b1;	// busy or beaten by a request
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < `ICACHE_SETS; s++) begin
				victim[s] <= '0;
			end
		end else if (refill_done) begin
			if (victim[line_index] == WAY_W'(`ICACHE_WAYS - 1)) begin
				victim[line_index] <= '0;
			end else begin
				victim[line_index] <= victim[line_index] + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if ((state == ST_LOOKUP) && any_hit) begin
			resp_data <= hit_word;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_IDLE;
			resp_valid <= 1'b0;
			mem_req_valid <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req_fire) begin
						state <= ST_LOOKUP;
					end else if (fence_take) begin
						state <= ST_FENCE;
					end
				end
				ST_LOOKUP: begin
					if (any_hit) begin
						state <= ST_RESPOND;
						resp_valid <= 1'b1;
					end else begin
						state <= ST_REFILL;
						mem_req_valid <= 1'b1;	// whole line burst
					end
				end
				ST_REFILL: begin
					if (mem_req_valid && mem_req_ready) begin
						mem_req_valid <= 1'b0;
					end
					if (refill_done) begin
						state <= ST_LOOKUP;	// answer from the new line
					end
				end
				ST_RESPOND: begin
					if (resp_ready) begin
						resp_valid <= 1'b0;
						state <= ST_IDLE;
					end
				end
				ST_FENCE: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: hw/icache_hit_select.sv
/*
 * hit select
 * one-hot merge of the way lines and word pick by offset
 */
`include "icache_defines.svh"

module icache_hit_select (
	input  logic [`ICACHE_WAYS-1:0] hit_vec,
	input  icache_pkg::line_t line_vec [`ICACHE_WAYS],
	input  logic [`ICACHE_WSEL_W-1:0] word_sel,
	output logic any_hit,
	output logic [`ICACHE_WORD_W-1:0] word
);
	import icache_pkg::*;

	line_t sel_line;

	assign any_hit = |hit_vec;

	// at most one way hits, so an OR of masked lines is the mux
	always_comb begin
		sel_line = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (hit_vec[w]) begin
				sel_line = sel_line | line_vec[w];
			end
		end
	end

	assign word = sel_line[word_sel * `ICACHE_WORD_W +: `ICACHE_WORD_W];

endmodule

// File: hw/icache_way.sv
/*
 * one cache way
 * per-set tag, valid and line storage
 * tag compare and shift-in refill
 */
`include "icache_defines.svh"

module icache_way (
	input  logic clock,
	input  logic reset,
	input  icache_pkg::tag_t line_tag,
	input  logic [`ICACHE_INDEX_W-1:0] line_index,
	input  logic fill_sel,
	input  logic fill_shift,
	input  logic fill_last,
	input  logic [`ICACHE_WORD_W-1:0] fill_data,
	input  logic invalidate,
	output logic hit,
	output icache_pkg::line_t line_data
);
	import icache_pkg::*;

	tag_t tags [`ICACHE_SETS];
	line_t lines [`ICACHE_SETS];
	logic [`ICACHE_SETS-1:0] valid;

	logic beat_wr;	// beat for this way
	logic fill_done;

	assign beat_wr = fill_sel && fill_shift;
	assign fill_done = beat_wr && fill_last;

	// fence drops every line at once
	always_ff @(posedge clock) begin
		if (reset || invalidate) begin
			valid <= '0;
		end else if (fill_done) begin
			valid[line_index] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (fill_done) begin
			tags[line_index] <= line_tag;
		end
	end

	// beats come lowest word first, so each new one enters at the top
	always_ff @(posedge clock) begin
		if (beat_wr) begin
			lines[line_index] <= {fill_data,
				lines[line_index][`ICACHE_LINE_W-1:`ICACHE_WORD_W]};
		end
	end

	assign hit = valid[line_index] && (tags[line_index] == line_tag);
	assign line_data = lines[line_index];	// read out unqualified

endmodule

// File: hw/icache_pkg.sv
/*
 * instruction cache types
 * tag, line and the fetch address union
 */
`include "icache_defines.svh"

package icache_pkg;

	typedef logic [`ICACHE_TAG_W-1:0] tag_t;
	typedef logic [`ICACHE_LINE_W-1:0] line_t;

	// address split as the lookup sees it
	typedef struct packed {
		tag_t tag;
		logic [`ICACHE_INDEX_W-1:0] index;
		logic [`ICACHE_WSEL_W-1:0] word;
		logic [1:0] byte_off;	// always zero for word fetches
	} fetch_fields_t;

	// raw word for ports and burst address, fields for the lookup
	typedef union packed {
		logic [`ICACHE_ADDR_W-1:0] raw;
		fetch_fields_t f;
	} fetch_addr_t;

endpackage

// File: hw/icache_defines.svh
/*
 * instruction cache geometry macros
 * address, offset, index and way counts plus derived widths
 */
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

`define ICACHE_ADDR_W	32	// byte address bits
`define ICACHE_OFF_W	4	// byte offset in a 16-byte line
`define ICACHE_INDEX_W	2	// 4 sets
`define ICACHE_WAYS	2
`define ICACHE_WORD_W	32	// fetch word and memory beat

`define ICACHE_SETS	(1 << `ICACHE_INDEX_W)
`define ICACHE_LINE_W	(8 << `ICACHE_OFF_W)
`define ICACHE_BEATS	(`ICACHE_LINE_W / `ICACHE_WORD_W)
`define ICACHE_WSEL_W	(`ICACHE_OFF_W - 2)	// word offset inside a line
`define ICACHE_TAG_W	(`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFF_W)

`endif
